/* Makefile */
# Verilator build and run of the front end testbench

SOURCES := $(filter-out +%,$(shell cat all.f)) $(wildcard common/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_front_end
	@out="$$(./obj_dir/Vtb_front_end)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

obj_dir/Vtb_front_end: all.f $(SOURCES)
	verilator --binary --assert -j 0 --top-module tb_front_end -f all.f

clean:
	rm -rf obj_dir

/* all.f */
+incdir+common
common/front_end_pkg.sv
hw/fetch/pc_generator.sv
hw/fetch/instruction_buffer.sv
hw/align/align_fsm.sv
hw/align/instruction_assembler.sv
hw/front_end.sv
verification/tb_front_end.sv

/* common/front_end_defs.svh */
// ==============================
// Front end constants
// Reset PC, address steps, buffer depth and the full-instruction opcode
// ==============================

`ifndef FRONT_END_DEFS_SVH
`define FRONT_END_DEFS_SVH

// First fetch address after reset
`define FE_RESET_PC 32'h0000_0000

// Sequential fetch increment and upper-half offset
`define FE_WORD_STEP 32'd4
`define FE_HALF_STEP 32'd2

// Default depth of the instruction buffer, a power of two
`define FE_BUFFER_DEPTH 8

// Low two bits of a parcel that starts a 32-bit instruction
`define FE_FULL_OPCODE 2'b11

`endif

/* common/front_end_pkg.sv */
// ==============================
// Front end package
// Vector types for words, addresses and parcels, and the aligner state
// ==============================

package front_end_pkg;

    // One instruction-memory word
    typedef logic [31:0] word_t;

    // Byte address
    typedef logic [31:0] addr_t;

    // One 16-bit instruction parcel
    typedef logic [15:0] half_t;

    // Where the next instruction starts relative to the buffer head
    typedef enum logic [1:0] {
        ALIGN_LOW   = 2'b00,
        ALIGN_UPPER = 2'b01,
        ALIGN_CROSS = 2'b10
    } align_state_e;

endpackage : front_end_pkg

/* hw/align/align_fsm.sv */
// ==============================
// Aligner FSM
// Picks the halfword that starts the next instruction and pops the buffer
// ==============================

`include "front_end_defs.svh"

module align_fsm (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         stall_i,
    input  logic                         head_ready_i,
    input  front_end_pkg::word_t         head_word_i,
    input  front_end_pkg::addr_t         head_addr_i,
    output front_end_pkg::align_state_e  state_o,
    output logic                         pop_o,
    output logic                         load_o,
    output logic                         emit_o
);

    front_end_pkg::align_state_e state_q;
    front_end_pkg::align_state_e state_d;
    front_end_pkg::align_state_e upper_next;

    logic misaligned;
    logic low_full;
    logic upper_full;

    assign misaligned = (head_addr_i[1:0] != 2'b00);
    assign low_full   = (head_word_i[1:0] == `FE_FULL_OPCODE);
    assign upper_full = (head_word_i[17:16] == `FE_FULL_OPCODE);

    // Where to go once the head's upper half is the start of the next instruction
    assign upper_next = upper_full ? front_end_pkg::ALIGN_CROSS : front_end_pkg::ALIGN_UPPER;

    always_comb begin
        state_d = state_q;
        pop_o   = 1'b0;
        emit_o  = 1'b0;
        if (!stall_i) begin
            case (state_q)
                front_end_pkg::ALIGN_LOW: begin
                    if (head_ready_i) begin
                        pop_o  = 1'b1;
                        emit_o = 1'b1;
                        // A misaligned entry is reported as a whole and not split
                        if (!misaligned && !low_full) begin
                            state_d = upper_next;
                        end
                    end
                end
                front_end_pkg::ALIGN_UPPER: begin
                    // The saved half is complete on its own
                    emit_o  = 1'b1;
                    state_d = front_end_pkg::ALIGN_LOW;
                end
                front_end_pkg::ALIGN_CROSS: begin
                    if (head_ready_i) begin
                        pop_o   = 1'b1;
                        emit_o  = 1'b1;
                        state_d = upper_next;
                    end
                end
                default: begin
                    state_d = front_end_pkg::ALIGN_LOW;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= front_end_pkg::ALIGN_LOW;
        end else if (flush_i) begin
            state_q <= front_end_pkg::ALIGN_LOW;
        end else begin
            state_q <= state_d;
        end
    end

    // The output register follows the back end stall
    assign load_o  = !stall_i;
    assign state_o = state_q;

endmodule : align_fsm

/* hw/align/instruction_assembler.sv */
// ==============================
// Instruction assembler
// Fuses halfwords into instructions and holds the fetch-stage register
// ==============================

`include "front_end_defs.svh"

module instruction_assembler (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  front_end_pkg::align_state_e  state_i,
    input  logic                         pop_i,
    input  logic                         load_i,
    input  logic                         emit_i,
    input  front_end_pkg::word_t         head_word_i,
    input  front_end_pkg::addr_t         head_addr_i,
    output front_end_pkg::word_t         instr_o,
    output front_end_pkg::addr_t         pc_o,
    output logic                         compressed_o,
    output logic                         exception_o,
    output logic                         valid_o
);

    front_end_pkg::half_t saved_half_q;
    front_end_pkg::addr_t saved_addr_q;

    front_end_pkg::word_t instr_d;
    front_end_pkg::addr_t pc_d;
    logic                 compressed_d;
    logic                 exception_d;

    // Upper half of every consumed word is kept for the next instruction
    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            saved_half_q <= head_word_i[31:16];
            saved_addr_q <= head_addr_i;
        end
    end

    // ==============================
    // Instruction forming
    // ==============================

    always_comb begin
        instr_d      = head_word_i;
        pc_d         = saved_addr_q + `FE_HALF_STEP;
        compressed_d = 1'b0;
        exception_d  = 1'b0;
        case (state_i)
            front_end_pkg::ALIGN_UPPER: begin
                instr_d      = {16'h0000, saved_half_q};
                compressed_d = 1'b1;
            end
            front_end_pkg::ALIGN_CROSS: begin
                // Head's low half is the upper parcel of the crossing instruction
                instr_d = {head_word_i[15:0], saved_half_q};
            end
            default: begin
                pc_d        = head_addr_i;
                exception_d = (head_addr_i[1:0] != 2'b00);
                if (head_word_i[1:0] != `FE_FULL_OPCODE) begin
                    instr_d      = {16'h0000, head_word_i[15:0]};
                    compressed_d = 1'b1;
                end
            end
        endcase
    end

    // ==============================
    // Fetch-stage register
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= emit_i;
        end
    end

    // Payload changes only with a new instruction
    always_ff @(posedge clk_i) begin
        if (load_i && emit_i) begin
            instr_o      <= instr_d;
            pc_o         <= pc_d;
            compressed_o <= compressed_d;
            exception_o  <= exception_d;
        end
    end

    // ==============================
    // Assertions
    // ==============================

    // A crossing instruction begins with the low parcel of a full instruction
    a_cross_starts_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (emit_i && state_i == front_end_pkg::ALIGN_CROSS)
            |-> (saved_half_q[1:0] == `FE_FULL_OPCODE)
    );

    // A saved half emitted on its own is a compressed parcel
    a_upper_is_compressed : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (emit_i && state_i == front_end_pkg::ALIGN_UPPER)
            |-> (saved_half_q[1:0] != `FE_FULL_OPCODE)
    );

endmodule : instruction_assembler

/* hw/fetch/instruction_buffer.sv */
// ==============================
// Instruction buffer
// FIFO of fetch addresses and the words that memory returns for them
// ==============================

`include "front_end_defs.svh"

module instruction_buffer #(
    parameter int DEPTH = `FE_BUFFER_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  front_end_pkg::addr_t push_addr_i,
    input  logic                 push_addr_valid_i,
    input  front_end_pkg::word_t push_word_i,
    input  logic                 push_word_valid_i,
    input  logic                 pop_i,
    output front_end_pkg::word_t head_word_o,
    output front_end_pkg::addr_t head_addr_o,
    output logic                 head_ready_o,
    output logic                 full_o
);

    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    front_end_pkg::addr_t addr_mem [DEPTH];
    front_end_pkg::word_t word_mem [DEPTH];

    ptr_t addr_wr_ptr_q;
    ptr_t word_wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t addr_count_q;
    cnt_t word_count_q;
    logic word_write;

    // Words that cross a flush belong to requests the memory has dropped
    assign word_write = push_word_valid_i & !flush_i;

    // ==============================
    // Storage
    // ==============================

    // On a flush the new address goes to slot 0 and becomes the only entry
    always_ff @(posedge clk_i) begin
        if (push_addr_valid_i) begin
            addr_mem[flush_i ? ptr_t'(0) : addr_wr_ptr_q] <= push_addr_i;
        end
        if (word_write) begin
            word_mem[word_wr_ptr_q] <= push_word_i;
        end
    end

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            addr_wr_ptr_q <= '0;
            word_wr_ptr_q <= '0;
            rd_ptr_q      <= '0;
            addr_count_q  <= '0;
            word_count_q  <= '0;
        end else if (flush_i) begin
            addr_wr_ptr_q <= ptr_t'(push_addr_valid_i);
            word_wr_ptr_q <= '0;
            rd_ptr_q      <= '0;
            addr_count_q  <= cnt_t'(push_addr_valid_i);
            word_count_q  <= '0;
        end else begin
            if (push_addr_valid_i) begin
                addr_wr_ptr_q <= addr_wr_ptr_q + ptr_t'(1);
            end
            if (word_write) begin
                word_wr_ptr_q <= word_wr_ptr_q + ptr_t'(1);
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            addr_count_q <= addr_count_q + cnt_t'(push_addr_valid_i) - cnt_t'(pop_i);
            word_count_q <= word_count_q + cnt_t'(word_write) - cnt_t'(pop_i);
        end
    end

    assign head_word_o  = word_mem[rd_ptr_q];
    assign head_addr_o  = addr_mem[rd_ptr_q];
    assign head_ready_o = (word_count_q != '0);
    assign full_o       = (addr_count_q == cnt_t'(DEPTH));

    // ==============================
    // Assertions
    // ==============================

    // The aligner only consumes entries whose word has arrived
    a_pop_when_ready : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> head_ready_o
    );

    // Memory answers only requests that are still outstanding
    a_word_has_addr : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        word_write |-> (addr_count_q != word_count_q)
    );

endmodule : instruction_buffer

/* hw/fetch/pc_generator.sv */
// ==============================
// PC generator
// Next fetch address by priority, fetch and invalidate strobes
// ==============================

`include "front_end_defs.svh"

module pc_generator (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 trap_i,
    input  front_end_pkg::addr_t trap_pc_i,
    input  logic                 trap_return_i,
    input  front_end_pkg::addr_t return_pc_i,
    input  logic                 branch_taken_i,
    input  front_end_pkg::addr_t branch_target_i,
    input  logic                 buffer_full_i,
    output logic                 fetch_o,
    output front_end_pkg::addr_t fetch_addr_o,
    output logic                 invalidate_o
);

    front_end_pkg::addr_t pc_q;
    logic                 redirect;
    logic                 run_q;

    // Goes high one edge after reset is released, keeps strobes quiet until then
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Trap entry beats trap return, which beats a resolved branch
    always_comb begin
        redirect     = 1'b1;
        fetch_addr_o = pc_q + `FE_WORD_STEP;
        if (trap_i) begin
            fetch_addr_o = trap_pc_i;
        end else if (trap_return_i) begin
            fetch_addr_o = return_pc_i;
        end else if (branch_taken_i) begin
            fetch_addr_o = branch_target_i;
        end else begin
            redirect = 1'b0;
        end
    end

    // A redirect flushes the buffer, so it may fetch even when full
    assign invalidate_o = run_q & redirect;
    assign fetch_o      = run_q & (redirect | !buffer_full_i);

    // Starts one word below the reset PC so the first sequential fetch lands on it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `FE_RESET_PC - `FE_WORD_STEP;
        end else if (fetch_o) begin
            pc_q <= fetch_addr_o;
        end
    end

    // ==============================
    // Assertions
    // ==============================

    // Sequential fetch must respect the buffer occupancy
    a_no_fetch_when_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (fetch_o && buffer_full_i) |-> invalidate_o
    );

endmodule : pc_generator

/* hw/front_end.sv */
// ==============================
// Instruction fetch front end
// PC generator, buffer, aligner FSM and assembler
// ==============================

module front_end (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Redirects and stall from the back end
    input  logic                 trap_i,
    input  front_end_pkg::addr_t trap_pc_i,
    input  logic                 trap_return_i,
    input  front_end_pkg::addr_t return_pc_i,
    input  logic                 branch_taken_i,
    input  front_end_pkg::addr_t branch_target_i,
    input  logic                 stall_i,
    // Instruction memory
    output logic                 fetch_o,
    output front_end_pkg::addr_t fetch_addr_o,
    output logic                 invalidate_o,
    input  logic                 mem_valid_i,
    input  front_end_pkg::word_t mem_word_i,
    // Fetch-stage output
    output front_end_pkg::word_t instr_o,
    output front_end_pkg::addr_t pc_o,
    output logic                 compressed_o,
    output logic                 exception_o,
    output logic                 valid_o
);

    logic                        buffer_full;
    logic                        head_ready;
    front_end_pkg::word_t        head_word;
    front_end_pkg::addr_t        head_addr;
    front_end_pkg::align_state_e align_state;
    logic                        pop;
    logic                        load;
    logic                        emit;

    pc_generator pc_generator_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .trap_i          (trap_i),
        .trap_pc_i       (trap_pc_i),
        .trap_return_i   (trap_return_i),
        .return_pc_i     (return_pc_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .buffer_full_i   (buffer_full),
        .fetch_o         (fetch_o),
        .fetch_addr_o    (fetch_addr_o),
        .invalidate_o    (invalidate_o)
    );

    // Every redirect flushes the buffer, the aligner and the output register
    instruction_buffer instruction_buffer_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (invalidate_o),
        .push_addr_i       (fetch_addr_o),
        .push_addr_valid_i (fetch_o),
        .push_word_i       (mem_word_i),
        .push_word_valid_i (mem_valid_i),
        .pop_i             (pop),
        .head_word_o       (head_word),
        .head_addr_o       (head_addr),
        .head_ready_o      (head_ready),
        .full_o            (buffer_full)
    );

    align_fsm align_fsm_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (invalidate_o),
        .stall_i      (stall_i),
        .head_ready_i (head_ready),
        .head_word_i  (head_word),
        .head_addr_i  (head_addr),
        .state_o      (align_state),
        .pop_o        (pop),
        .load_o       (load),
        .emit_o       (emit)
    );

    instruction_assembler instruction_assembler_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (invalidate_o),
        .state_i      (align_state),
        .pop_i        (pop),
        .load_i       (load),
        .emit_i       (emit),
        .head_word_i  (head_word),
        .head_addr_i  (head_addr),
        .instr_o      (instr_o),
        .pc_o         (pc_o),
        .compressed_o (compressed_o),
        .exception_o  (exception_o),
        .valid_o      (valid_o)
    );

endmodule : front_end

/* verification/tb_front_end.sv */
// ==============================
// Front end testbench
// Random memory with delayed answers, redirects and stalls, checked
// against a halfword walk of the same memory
// ==============================

`include "front_end_defs.svh"

module tb_front_end;

    localparam int CLK_PERIOD   = 10;
    localparam int MEM_AW       = 10;
    localparam int MEM_HALVES   = 1 << MEM_AW;
    localparam int FULL_LEN     = 64;
    localparam int MIXED_LEN    = 300;
    localparam int REDIRECT_LEN = 300;
    localparam int STALL_LEN    = 300;
    localparam int MISALIGN_LEN = 200;
    localparam int TOTAL_LEN    = FULL_LEN + MIXED_LEN + REDIRECT_LEN
                                  + STALL_LEN + MISALIGN_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_LEN * 20;

    typedef logic [MEM_AW-1:0] mem_idx_t;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 trap_i;
    front_end_pkg::addr_t trap_pc_i;
    logic                 trap_return_i;
    front_end_pkg::addr_t return_pc_i;
    logic                 branch_taken_i;
    front_end_pkg::addr_t branch_target_i;
    logic                 stall_i;
    logic                 fetch_o;
    front_end_pkg::addr_t fetch_addr_o;
    logic                 invalidate_o;
    logic                 mem_valid_i;
    front_end_pkg::word_t mem_word_i;
    front_end_pkg::word_t instr_o;
    front_end_pkg::addr_t pc_o;
    logic                 compressed_o;
    logic                 exception_o;
    logic                 valid_o;

    front_end front_end_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .trap_i          (trap_i),
        .trap_pc_i       (trap_pc_i),
        .trap_return_i   (trap_return_i),
        .return_pc_i     (return_pc_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .stall_i         (stall_i),
        .fetch_o         (fetch_o),
        .fetch_addr_o    (fetch_addr_o),
        .invalidate_o    (invalidate_o),
        .mem_valid_i     (mem_valid_i),
        .mem_word_i      (mem_word_i),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .compressed_o    (compressed_o),
        .exception_o     (exception_o),
        .valid_o         (valid_o)
    );

    // Memory model with one entry per 16-bit parcel
    logic [15:0]          mem_half [MEM_HALVES];
    front_end_pkg::addr_t req_addr_q [$];
    int                   req_due_q [$];
    int                   cycle_count;

    string       test_name;
    int unsigned stall_pct;
    int unsigned redirect_pct;
    int unsigned misalign_pct;
    int          steps_since_reset;

    // Reference model state
    front_end_pkg::addr_t exp_pc;
    bit                   exp_misaligned;
    bit                   first_after_misaligned;
    front_end_pkg::addr_t misaligned_target;
    bit                   first_fetch_pending;
    int                   delivered;

    bit                   hold_pending;
    front_end_pkg::word_t held_instr;
    front_end_pkg::addr_t held_pc;
    logic [1:0]           held_flags;

    int check_count;
    int error_count;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [15:0] half_at(input front_end_pkg::addr_t addr);
        return mem_half[mem_idx_t'(addr >> 1)];
    endfunction

    // Memory answers with the word at the address with its low two bits cleared
    function automatic front_end_pkg::word_t word_at(input front_end_pkg::addr_t addr);
        front_end_pkg::addr_t base;
        base = {addr[31:2], 2'b00};
        return {half_at(base + 32'd2), half_at(base)};
    endfunction

    function automatic front_end_pkg::addr_t pick_target();
        front_end_pkg::addr_t target;
        target = ($urandom % (MEM_HALVES / 2)) * 32'd4;
        if (($urandom % 100) < misalign_pct) begin
            target[1:0] = 2'(1 + $urandom % 3);
        end
        return target;
    endfunction

    task automatic fill_memory(input bit full_only);
        logic [15:0] parcel;
        int          i;
        for (i = 0; i < MEM_HALVES; i++) begin
            parcel = 16'($urandom);
            if (full_only) begin
                // Every word starts a 32-bit instruction
                if (i % 2 == 0) begin
                    parcel[1:0] = `FE_FULL_OPCODE;
                end
            end else if (($urandom % 2) == 32'd0) begin
                parcel[1:0] = 2'($urandom % 3);
            end else begin
                parcel[1:0] = `FE_FULL_OPCODE;
            end
            mem_half[mem_idx_t'(i)] = parcel;
        end
    endtask

    // Predicts the next instruction of the walk
    // A misaligned stream advances one word at a time
    task automatic predict_instr(
        input  front_end_pkg::addr_t pc,
        input  bit                   misaligned,
        output front_end_pkg::word_t instr,
        output logic                 compressed,
        output front_end_pkg::addr_t next_pc
    );
        front_end_pkg::word_t parcels;
        if (misaligned) begin
            parcels = word_at(pc);
        end else begin
            parcels = {half_at(pc + 32'd2), half_at(pc)};
        end
        if (parcels[1:0] == `FE_FULL_OPCODE) begin
            instr      = parcels;
            compressed = 1'b0;
            next_pc    = pc + 32'd4;
        end else begin
            instr      = {16'h0000, parcels[15:0]};
            compressed = 1'b1;
            next_pc    = misaligned ? pc + 32'd4 : pc + 32'd2;
        end
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic restart_model(input front_end_pkg::addr_t target);
        exp_pc                 = target;
        exp_misaligned         = (target[1:0] != 2'b00);
        first_after_misaligned = exp_misaligned;
        misaligned_target      = target;
    endtask

    task automatic check_delivery();
        front_end_pkg::word_t exp_instr;
        logic                 exp_compressed;
        front_end_pkg::addr_t next_pc;
        predict_instr(exp_pc, exp_misaligned, exp_instr, exp_compressed, next_pc);
        if (first_after_misaligned) begin
            check_value({test_name, " misaligned pc"}, misaligned_target, pc_o);
            check_value({test_name, " misaligned exception"}, 32'd1, 32'(exception_o));
            first_after_misaligned = 1'b0;
        end
        check_value({test_name, " pc"}, exp_pc, pc_o);
        check_value({test_name, " instr"}, exp_instr, instr_o);
        check_value({test_name, " compressed"}, 32'(exp_compressed), 32'(compressed_o));
        check_value({test_name, " exception"}, 32'(exp_misaligned), 32'(exception_o));
        exp_pc = next_pc;
        delivered++;
    endtask

    task automatic apply_reset(input bit full_only);
        int n;
        @(negedge clk_i);
        rst_n_i        = 1'b0;
        stall_i        = 1'b0;
        trap_i         = 1'b0;
        trap_return_i  = 1'b0;
        branch_taken_i = 1'b0;
        mem_valid_i    = 1'b0;
        req_addr_q.delete();
        req_due_q.delete();
        fill_memory(full_only);
        for (n = 0; n < 4; n++) begin
            @(negedge clk_i);
            check_value({test_name, " reset valid"}, 32'd0, 32'(valid_o));
            check_value({test_name, " reset fetch"}, 32'd0, 32'(fetch_o));
            check_value({test_name, " reset invalidate"}, 32'd0, 32'(invalidate_o));
        end
        rst_n_i = 1'b1;
        restart_model(`FE_RESET_PC);
        first_fetch_pending = 1'b1;
        hold_pending        = 1'b0;
        steps_since_reset   = 0;
        delivered           = 0;
    endtask

    // ==============================
    // One clock cycle of stimulus
    // ==============================

    task automatic step_cycle();
        logic                 do_trap;
        logic                 do_return;
        logic                 do_branch;
        logic                 do_stall;
        logic                 redirect;
        front_end_pkg::addr_t target;

        @(negedge clk_i);
        cycle_count++;
        steps_since_reset++;
        do_stall  = ($urandom % 100) < stall_pct;
        do_trap   = 1'b0;
        do_return = 1'b0;
        do_branch = 1'b0;
        // The first cycles after reset belong to the sequential fetch
        if (steps_since_reset > 2 && ($urandom % 100) < redirect_pct) begin
            do_trap   = ($urandom % 3) == 32'd0;
            do_return = ($urandom % 3) == 32'd0;
            do_branch = !(do_trap || do_return) || ($urandom % 2) == 32'd0;
        end
        redirect = do_trap | do_return | do_branch;

        stall_i         = do_stall;
        trap_i          = do_trap;
        trap_return_i   = do_return;
        branch_taken_i  = do_branch;
        trap_pc_i       = pick_target();
        return_pc_i     = pick_target();
        branch_target_i = pick_target();
        target = do_trap ? trap_pc_i : (do_return ? return_pc_i : branch_target_i);

        // A redirect kills outstanding requests and the rest are answered in order
        mem_valid_i = 1'b0;
        if (redirect) begin
            req_addr_q.delete();
            req_due_q.delete();
        end else if (req_due_q.size() > 0 && req_due_q[0] <= cycle_count) begin
            mem_valid_i = 1'b1;
            mem_word_i  = word_at(req_addr_q.pop_front());
            void'(req_due_q.pop_front());
        end

        #1;
        check_value({test_name, " invalidate"}, 32'(redirect), 32'(invalidate_o));
        if (redirect) begin
            check_value({test_name, " redirect fetch"}, 32'd1, 32'(fetch_o));
            check_value({test_name, " redirect target"}, target, fetch_addr_o);
        end
        // The first cycle after reset fetches from the reset PC
        if (first_fetch_pending) begin
            check_value({test_name, " first fetch strobe"}, 32'd1, 32'(fetch_o));
            check_value({test_name, " first fetch"}, `FE_RESET_PC, fetch_addr_o);
            first_fetch_pending = 1'b0;
        end
        if (fetch_o === 1'b1) begin
            req_addr_q.push_back(fetch_addr_o);
            req_due_q.push_back(cycle_count + 1 + int'($urandom % 3));
        end

        if (hold_pending) begin
            check_value({test_name, " hold valid"}, 32'd1, 32'(valid_o));
            check_value({test_name, " hold instr"}, held_instr, instr_o);
            check_value({test_name, " hold pc"}, held_pc, pc_o);
            check_value({test_name, " hold flags"}, 32'(held_flags),
                        32'({compressed_o, exception_o}));
        end
        hold_pending = (valid_o === 1'b1) && do_stall && !redirect;
        held_instr   = instr_o;
        held_pc      = pc_o;
        held_flags   = {compressed_o, exception_o};

        // The instruction on the output leaves on this edge unless stalled
        if (valid_o === 1'b1 && !do_stall) begin
            check_delivery();
        end
        if (redirect) begin
            restart_model(target);
        end
    endtask

    task automatic run_test(
        input string       name,
        input int          count,
        input int unsigned stall,
        input int unsigned redirects,
        input int unsigned misaligned,
        input bit          full_only
    );
        test_name    = name;
        stall_pct    = stall;
        redirect_pct = redirects;
        misalign_pct = misaligned;
        apply_reset(full_only);
        while (delivered < count) begin
            step_cycle();
        end
        $display("Test %s done, %0d instructions delivered", name, delivered);
    endtask

    // ==============================
    // Watchdog
    // ==============================

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: test %s did not finish within %0d cycles",
                 test_name, WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hdcb7));
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        trap_i          = 1'b0;
        trap_pc_i       = '0;
        trap_return_i   = 1'b0;
        return_pc_i     = '0;
        branch_taken_i  = 1'b0;
        branch_target_i = '0;
        stall_i         = 1'b0;
        mem_valid_i     = 1'b0;
        mem_word_i      = '0;
        check_count     = 0;
        error_count     = 0;
        cycle_count     = 0;

        run_test("full_stream", FULL_LEN, 0, 0, 0, 1'b1);
        run_test("mixed_walk", MIXED_LEN, 0, 0, 0, 1'b0);
        run_test("redirect", REDIRECT_LEN, 0, 6, 0, 1'b0);
        run_test("stall", STALL_LEN, 35, 0, 0, 1'b0);
        run_test("misaligned", MISALIGN_LEN, 20, 8, 50, 1'b0);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_front_end
